/* soc_params.svh */
// Peripheral subsystem parameters
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Upper address half of the peripheral window
`define SOC_APB_BASE      16'h1006

// Slot indices, decoded from address bits 15:12
`define SOC_SLOT_GPIO     0
`define SOC_SLOT_IRQ      1
`define SOC_SLOT_PNP      2
`define SOC_SLOT_TOTAL    3

// Pin and interrupt counts
`define SOC_GPIO_WIDTH    12
`define SOC_EXT_IRQ_WIDTH 4
`define SOC_IRQ_TOTAL     16

// Identity codes reported by the PnP table
`define SOC_HW_ID         32'h5e1f_0a01
`define SOC_VENDOR_ID     16'h00f1
`define SOC_DEV_GPIO      16'h0060
`define SOC_DEV_IRQ       16'h0061
`define SOC_DEV_PNP       16'h0062

`endif

/* soc_pkg.sv */
// Peripheral bus types
`include "soc_params.svh"

package soc_pkg;

  // APB request to one slave
  // Offset only, the bridge strips the window and slot bits
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_in_t;

  // APB response from one slave
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
  } apb_out_t;

  // Address range of one slot
  typedef struct packed {
    logic [31:0] addr_start;
    logic [31:0] addr_end;
  } mapinfo_t;

  // Slot descriptor as listed by the PnP table
  typedef struct packed {
    logic [15:0] vendor;
    logic [15:0] device;
    logic [31:0] addr_start;
    logic [31:0] addr_end;
  } dev_cfg_t;

  // Single word host request
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } host_req_t;

  // Host response, err set on unmapped access
  typedef struct packed {
    logic        err;
    logic [31:0] rdata;
  } host_resp_t;

  // Per slot vectors
  typedef apb_in_t  [`SOC_SLOT_TOTAL-1:0] apb_in_vec_t;
  typedef apb_out_t [`SOC_SLOT_TOTAL-1:0] apb_out_vec_t;
  typedef mapinfo_t [`SOC_SLOT_TOTAL-1:0] mapinfo_vec_t;
  typedef dev_cfg_t [`SOC_SLOT_TOTAL-1:0] dev_cfg_vec_t;

endpackage

/* apb_bridge.sv */
// Host to APB bridge
`include "soc_params.svh"

module apb_bridge
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  // Host strobe port
  input  logic                  i_req,
  input  soc_pkg::host_req_t    i_host,
  output logic                  o_busy,
  output logic                  o_resp_valid,
  output soc_pkg::host_resp_t   o_resp,
  // APB slots
  output soc_pkg::apb_in_vec_t  o_apbi,
  input  soc_pkg::apb_out_vec_t i_apbo,
  output soc_pkg::mapinfo_vec_t o_mapinfo
);

  import soc_pkg::*;

  localparam int SLOT_W = $clog2(`SOC_SLOT_TOTAL);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e                     r_state;
  logic                       r_resp_valid;
  host_req_t                  r_req;
  host_resp_t                 r_resp;
  logic                       r_hit;
  logic [SLOT_W-1:0]          r_slot;
  logic                       w_accept;
  logic                       w_hit;
  logic [`SOC_SLOT_TOTAL-1:0] w_psel;

  //////////////////////////////
  // Request decode

  // Window match and slot inside the populated range
  assign w_hit = (i_host.addr[31:16] == `SOC_APB_BASE)
              && (i_host.addr[15:12] < 4'(`SOC_SLOT_TOTAL));
  // Busy until the response pulse has been seen
  assign o_busy   = (r_state != ST_IDLE) || r_resp_valid;
  assign w_accept = i_req && !o_busy;

  // Idle, setup, access, then back to idle with the response
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      r_state      <= ST_IDLE;
      r_resp_valid <= 1'b0;
    end
    else
    begin
      r_resp_valid <= 1'b0;
      case (r_state)
        ST_IDLE:
          if (w_accept)
            r_state <= ST_SETUP;
        ST_SETUP:
          r_state <= ST_ACCESS;
        ST_ACCESS:
        begin
          r_state      <= ST_IDLE;
          r_resp_valid <= 1'b1;
        end
        default:
          r_state <= ST_IDLE;
      endcase
    end
  end

  // Request held for the whole transfer
  // Response data taken at the end of access
  always_ff @(posedge i_clk)
  begin
    if (w_accept)
    begin
      r_req  <= i_host;
      r_hit  <= w_hit;
      r_slot <= i_host.addr[12 +: SLOT_W];
    end
    if (r_state == ST_ACCESS)
    begin
      r_resp.err   <= !(r_hit && i_apbo[r_slot].pready);
      r_resp.rdata <= r_hit ? i_apbo[r_slot].prdata : 32'h0;
    end
  end

  assign o_resp_valid = r_resp_valid;
  assign o_resp       = r_resp;

  //////////////////////////////
  // Slot outputs and address map

  for (genvar i = 0; i < `SOC_SLOT_TOTAL; i++)
  begin : g_slot
    // Only the decoded slot sees psel
    assign w_psel[i]         = (r_state != ST_IDLE) && r_hit && (r_slot == SLOT_W'(i));
    assign o_apbi[i].psel    = w_psel[i];
    assign o_apbi[i].penable = w_psel[i] && (r_state == ST_ACCESS);
    assign o_apbi[i].pwrite  = r_req.we;
    assign o_apbi[i].paddr   = r_req.addr[11:0];
    assign o_apbi[i].pwdata  = r_req.wdata;
    // 4 KB per slot
    assign o_mapinfo[i].addr_start = {`SOC_APB_BASE, 4'(i), 12'h000};
    assign o_mapinfo[i].addr_end   = {`SOC_APB_BASE, 4'(i), 12'hfff};

    // A slot in setup reaches access on the next edge
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_apbi[i].psel && !o_apbi[i].penable) |=> (o_apbi[i].psel && o_apbi[i].penable));
  end

  // Never more than one slot selected
  assert property (@(posedge i_clk) disable iff (!i_rst_n) $onehot0(w_psel));

endmodule

/* apb_gpio.sv */
// GPIO controller
`include "soc_params.svh"

module apb_gpio
(
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  soc_pkg::mapinfo_t          i_mapinfo,
  output soc_pkg::dev_cfg_t          o_cfg,
  input  soc_pkg::apb_in_t           i_apbi,
  output soc_pkg::apb_out_t          o_apbo,
  // Pins
  input  logic [`SOC_GPIO_WIDTH-1:0] i_gpio,
  output logic [`SOC_GPIO_WIDTH-1:0] o_gpio,
  output logic [`SOC_GPIO_WIDTH-1:0] o_gpio_dir,
  // Per pin pending
  output logic [`SOC_GPIO_WIDTH-1:0] o_irq
);

  localparam int GW = `SOC_GPIO_WIDTH;

  logic [GW-1:0] r_dir;
  logic [GW-1:0] r_out;
  logic [GW-1:0] r_ie;
  logic [GW-1:0] r_pend;
  logic [GW-1:0] r_sync1;
  logic [GW-1:0] r_sync2;
  logic [GW-1:0] r_prev;
  logic [GW-1:0] w_rise;
  logic [GW-1:0] w_clr;
  logic          w_wr;
  logic [31:0]   vb_rdata;

  // Own descriptor
  assign o_cfg.vendor     = `SOC_VENDOR_ID;
  assign o_cfg.device     = `SOC_DEV_GPIO;
  assign o_cfg.addr_start = i_mapinfo.addr_start;
  assign o_cfg.addr_end   = i_mapinfo.addr_end;

  //////////////////////////////
  // Register section

  // Writes land at the end of access
  assign w_wr  = i_apbi.psel && i_apbi.penable && i_apbi.pwrite;
  // Write 1 to clear pending
  assign w_clr = (w_wr && (i_apbi.paddr == 12'h010)) ? i_apbi.pwdata[GW-1:0] : '0;

  always_comb
  begin
    vb_rdata = '0;
    case (i_apbi.paddr)
      12'h000: vb_rdata[GW-1:0] = r_dir;
      12'h004: vb_rdata[GW-1:0] = r_out;
      12'h008: vb_rdata[GW-1:0] = r_sync2;
      12'h00c: vb_rdata[GW-1:0] = r_ie;
      12'h010: vb_rdata[GW-1:0] = r_pend;
      default: vb_rdata = '0;
    endcase
  end

  assign o_apbo.prdata = vb_rdata;
  assign o_apbo.pready = i_apbi.psel && i_apbi.penable;

  //////////////////////////////
  // Pin logic

  // Two flop synchroniser, third flop for edge detect
  assign w_rise = r_sync2 & ~r_prev;

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      r_dir   <= '0;
      r_out   <= '0;
      r_ie    <= '0;
      r_pend  <= '0;
      r_sync1 <= '0;
      r_sync2 <= '0;
      r_prev  <= '0;
    end
    else
    begin
      r_sync1 <= i_gpio;
      r_sync2 <= r_sync1;
      r_prev  <= r_sync2;
      if (w_wr)
      begin
        case (i_apbi.paddr)
          12'h000: r_dir <= i_apbi.pwdata[GW-1:0];
          12'h004: r_out <= i_apbi.pwdata[GW-1:0];
          12'h00c: r_ie  <= i_apbi.pwdata[GW-1:0];
          default: ;
        endcase
      end
      // Only enabled pins latch an edge
      r_pend <= (r_pend & ~w_clr) | (w_rise & r_ie);
    end
  end

  // Output driven only where the direction bit selects output
  assign o_gpio     = r_out & r_dir;
  assign o_gpio_dir = r_dir;
  assign o_irq      = r_pend;

  // New pending bits only for pins enabled at the time
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    ((r_pend & ~$past(r_pend)) & ~$past(r_ie)) == '0);

endmodule

/* apb_irqctrl.sv */
// Interrupt controller
`include "soc_params.svh"

module apb_irqctrl
(
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  soc_pkg::mapinfo_t         i_mapinfo,
  output soc_pkg::dev_cfg_t         o_cfg,
  input  soc_pkg::apb_in_t          i_apbi,
  output soc_pkg::apb_out_t         o_apbo,
  // GPIO lines low, external lines high
  input  logic [`SOC_IRQ_TOTAL-1:0] i_irq_src,
  output logic                      o_irq
);

  localparam int IW = `SOC_IRQ_TOTAL;

  logic [IW-1:0] r_pend;
  logic [IW-1:0] r_ie;
  logic [IW-1:0] w_active;
  logic [IW-1:0] w_clr;
  logic          w_wr;
  logic [31:0]   vb_claim;
  logic [31:0]   vb_rdata;

  // Own descriptor
  assign o_cfg.vendor     = `SOC_VENDOR_ID;
  assign o_cfg.device     = `SOC_DEV_IRQ;
  assign o_cfg.addr_start = i_mapinfo.addr_start;
  assign o_cfg.addr_end   = i_mapinfo.addr_end;

  //////////////////////////////
  // Register section

  assign w_wr  = i_apbi.psel && i_apbi.penable && i_apbi.pwrite;
  assign w_clr = (w_wr && (i_apbi.paddr == 12'h000)) ? i_apbi.pwdata[IW-1:0] : '0;

  always_comb
  begin
    vb_rdata = '0;
    case (i_apbi.paddr)
      12'h000: vb_rdata[IW-1:0] = r_pend;
      12'h004: vb_rdata[IW-1:0] = r_ie;
      // Claim is a plain read, nothing is acknowledged
      12'h008: vb_rdata = vb_claim;
      default: vb_rdata = '0;
    endcase
  end

  assign o_apbo.prdata = vb_rdata;
  assign o_apbo.pready = i_apbi.psel && i_apbi.penable;

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      r_pend <= '0;
      r_ie   <= '0;
    end
    else
    begin
      if (w_wr && (i_apbi.paddr == 12'h004))
        r_ie <= i_apbi.pwdata[IW-1:0];
      // A source still high wins over the clear
      r_pend <= (r_pend & ~w_clr) | i_irq_src;
    end
  end

  //////////////////////////////
  // Interrupt logic

  assign w_active = r_pend & r_ie;

  // Lowest active index plus one, zero when idle
  always_comb
  begin
    vb_claim = '0;
    for (int i = IW - 1; i >= 0; i--)
    begin
      if (w_active[i])
        vb_claim = 32'(i + 1);
    end
  end

  assign o_irq = |w_active;

  // No interrupt while every source is masked
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (r_ie == '0) |-> !o_irq);

endmodule

/* apb_pnp.sv */
// Plug-and-play table
`include "soc_params.svh"

module apb_pnp
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  soc_pkg::mapinfo_t     i_mapinfo,
  output soc_pkg::dev_cfg_t     o_cfg,
  input  soc_pkg::apb_in_t      i_apbi,
  output soc_pkg::apb_out_t     o_apbo,
  // Descriptors of all slots, this one included
  input  soc_pkg::dev_cfg_vec_t i_cfg
);

  logic [31:0] r_rdata;
  logic [31:0] vb_rdata;
  logic [7:0]  vb_row;
  logic [7:0]  vb_idx;

  // Own descriptor, fed back through i_cfg at the top level
  assign o_cfg.vendor     = `SOC_VENDOR_ID;
  assign o_cfg.device     = `SOC_DEV_PNP;
  assign o_cfg.addr_start = i_mapinfo.addr_start;
  assign o_cfg.addr_end   = i_mapinfo.addr_end;

  // Row 0 is the header, row 1 + n describes slot n
  always_comb
  begin
    vb_rdata = '0;
    vb_row   = i_apbi.paddr[11:4];
    vb_idx   = vb_row - 8'd1;
    if (vb_row == 8'd0)
    begin
      case (i_apbi.paddr[3:2])
        2'd0:    vb_rdata = `SOC_HW_ID;
        2'd1:    vb_rdata = 32'(`SOC_SLOT_TOTAL);
        default: vb_rdata = '0;
      endcase
    end
    else if (vb_row <= 8'(`SOC_SLOT_TOTAL))
    begin
      case (i_apbi.paddr[3:2])
        2'd0:    vb_rdata = i_cfg[vb_idx].addr_start;
        2'd1:    vb_rdata = i_cfg[vb_idx].addr_end;
        2'd2:    vb_rdata = {i_cfg[vb_idx].vendor, i_cfg[vb_idx].device};
        default: vb_rdata = '0;
      endcase
    end
  end

  // Captured in setup, steady through access
  // Writes have no effect on the table
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
      r_rdata <= '0;
    else if (i_apbi.psel && !i_apbi.penable)
      r_rdata <= vb_rdata;
  end

  assign o_apbo.prdata = r_rdata;
  assign o_apbo.pready = i_apbi.psel && i_apbi.penable;

endmodule

/* soc_periph.sv */
// Peripheral subsystem top level
`include "soc_params.svh"

module soc_periph
(
  input  logic                          i_sys_clk,
  input  logic                          i_rst_n,
  // Host strobe port
  input  logic                          i_req,
  input  soc_pkg::host_req_t            i_host,
  output logic                          o_busy,
  output logic                          o_resp_valid,
  output soc_pkg::host_resp_t           o_resp,
  // GPIO pins
  input  logic [`SOC_GPIO_WIDTH-1:0]    i_gpio,
  output logic [`SOC_GPIO_WIDTH-1:0]    o_gpio,
  output logic [`SOC_GPIO_WIDTH-1:0]    o_gpio_dir,
  // Interrupts
  input  logic [`SOC_EXT_IRQ_WIDTH-1:0] i_ext_irq,
  output logic                          o_irq
);

  import soc_pkg::*;

  apb_in_vec_t                 apbi;
  wire apb_out_vec_t           apbo;
  mapinfo_vec_t                bus1_mapinfo;
  wire dev_cfg_vec_t           dev_pnp;
  logic [`SOC_GPIO_WIDTH-1:0]  wb_irq_gpio;
  logic [`SOC_IRQ_TOTAL-1:0]   wb_irq_src;

  //////////////////////////////
  // Bridge, slot 0x1006_x000 decode
  apb_bridge bus1 (
    .i_clk(i_sys_clk),
    .i_rst_n(i_rst_n),
    .i_req(i_req),
    .i_host(i_host),
    .o_busy(o_busy),
    .o_resp_valid(o_resp_valid),
    .o_resp(o_resp),
    .o_apbi(apbi),
    .i_apbo(apbo),
    .o_mapinfo(bus1_mapinfo)
  );

  //////////////////////////////
  // GPIO at slot 0
  apb_gpio gpio0 (
    .i_clk(i_sys_clk),
    .i_rst_n(i_rst_n),
    .i_mapinfo(bus1_mapinfo[`SOC_SLOT_GPIO]),
    .o_cfg(dev_pnp[`SOC_SLOT_GPIO]),
    .i_apbi(apbi[`SOC_SLOT_GPIO]),
    .o_apbo(apbo[`SOC_SLOT_GPIO]),
    .i_gpio(i_gpio),
    .o_gpio(o_gpio),
    .o_gpio_dir(o_gpio_dir),
    .o_irq(wb_irq_gpio)
  );

  // GPIO pending in bits 11:0, external lines in 15:12
  assign wb_irq_src = {i_ext_irq, wb_irq_gpio};

  //////////////////////////////
  // Interrupt controller at slot 1
  apb_irqctrl irq0 (
    .i_clk(i_sys_clk),
    .i_rst_n(i_rst_n),
    .i_mapinfo(bus1_mapinfo[`SOC_SLOT_IRQ]),
    .o_cfg(dev_pnp[`SOC_SLOT_IRQ]),
    .i_apbi(apbi[`SOC_SLOT_IRQ]),
    .o_apbo(apbo[`SOC_SLOT_IRQ]),
    .i_irq_src(wb_irq_src),
    .o_irq(o_irq)
  );

  //////////////////////////////
  // PnP table at slot 2, reads back every descriptor
  apb_pnp pnp0 (
    .i_clk(i_sys_clk),
    .i_rst_n(i_rst_n),
    .i_mapinfo(bus1_mapinfo[`SOC_SLOT_PNP]),
    .o_cfg(dev_pnp[`SOC_SLOT_PNP]),
    .i_apbi(apbi[`SOC_SLOT_PNP]),
    .o_apbo(apbo[`SOC_SLOT_PNP]),
    .i_cfg(dev_pnp)
  );

endmodule

/* tb_soc_periph.sv */
// Peripheral subsystem testbench
`include "soc_params.svh"

module tb_soc_periph;

  import soc_pkg::*;

  localparam int GW = `SOC_GPIO_WIDTH;
  localparam int EW = `SOC_EXT_IRQ_WIDTH;
  localparam logic [31:0] GPIO_MASK = (32'd1 << GW) - 1;
  // About 60 transfers of 4 cycles plus pin waits stay far below this
  localparam int TIMEOUT_CYCLES = 2000;

  logic                 i_sys_clk = 1'b0;
  logic                 i_rst_n;
  logic                 i_req;
  host_req_t            i_host;
  logic                 o_busy;
  logic                 o_resp_valid;
  host_resp_t           o_resp;
  logic [GW-1:0]        i_gpio;
  logic [GW-1:0]        o_gpio;
  logic [GW-1:0]        o_gpio_dir;
  logic [EW-1:0]        i_ext_irq;
  logic                 o_irq;
  integer               seed = 32'h2b55c7b6;
  int                   cycle_count = 0;

  soc_periph i_soc_periph (
    .i_sys_clk(i_sys_clk),
    .i_rst_n(i_rst_n),
    .i_req(i_req),
    .i_host(i_host),
    .o_busy(o_busy),
    .o_resp_valid(o_resp_valid),
    .o_resp(o_resp),
    .i_gpio(i_gpio),
    .o_gpio(o_gpio),
    .o_gpio_dir(o_gpio_dir),
    .i_ext_irq(i_ext_irq),
    .o_irq(o_irq)
  );

  always #2 i_sys_clk = ~i_sys_clk;

  //////////////////////////////
  // Helpers

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped on first failure");
  endtask

  // Watchdog
  always @(posedge i_sys_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_on_failure("timeout, the tests did not finish within the cycle limit");
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      stop_on_failure($sformatf("error %s: expected %0h, actual %0h", name, expected, actual));
  endtask

  // Inputs change and outputs are sampled 1 unit after the edge
  task automatic next_cycle();
    @(posedge i_sys_clk);
    #1;
  endtask

  // Window base with the slot in bits 15:12 and the offset below
  function automatic logic [31:0] slot_addr(input logic [3:0] slot, input logic [11:0] offset);
    slot_addr = {`SOC_APB_BASE, slot, offset};
  endfunction

  function automatic logic [15:0] slot_device(input int slot);
    case (slot)
      `SOC_SLOT_GPIO: slot_device = `SOC_DEV_GPIO;
      `SOC_SLOT_IRQ:  slot_device = `SOC_DEV_IRQ;
      default:        slot_device = `SOC_DEV_PNP;
    endcase
  endfunction

  function automatic int lowest_set(input logic [EW-1:0] v);
    lowest_set = -1;
    for (int i = 0; i < EW; i++)
    begin
      if (v[i] && (lowest_set < 0))
        lowest_set = i;
    end
  endfunction

  //////////////////////////////
  // Host port tasks

  // One cycle strobe that returns just after the sampling edge
  task automatic send_request(input logic we, input logic [31:0] addr, input logic [31:0] wdata);
    while (o_busy)
      next_cycle();
    i_req        = 1'b1;
    i_host.we    = we;
    i_host.addr  = addr;
    i_host.wdata = wdata;
    next_cycle();
    i_req = 1'b0;
  endtask

  // Edges counted from the sampling edge
  task automatic wait_response(output host_resp_t resp, output int edges);
    edges = 1;
    while (!o_resp_valid)
    begin
      if (edges > 8)
        stop_on_failure("no response pulse arrived for a host request");
      else
      begin
        next_cycle();
        edges++;
      end
    end
    resp = o_resp;
  endtask

  task automatic host_read(input logic [31:0] addr, output host_resp_t resp);
    int edges;
    send_request(1'b0, addr, 32'h0);
    wait_response(resp, edges);
    check_value("read latency", 3, edges);
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] wdata);
    host_resp_t resp;
    int         edges;
    send_request(1'b1, addr, wdata);
    wait_response(resp, edges);
    check_value("write latency", 3, edges);
    check_value("write err", 0, resp.err);
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr,
                             input logic [31:0] expected);
    host_resp_t resp;
    host_read(addr, resp);
    check_value({name, " err"}, 0, resp.err);
    check_value(name, expected, resp.rdata);
  endtask

  //////////////////////////////
  // Tests

  task automatic test_reset();
    check_value("reset busy", 0, o_busy);
    check_value("reset resp valid", 0, o_resp_valid);
    check_value("reset gpio", 0, o_gpio);
    check_value("reset gpio dir", 0, o_gpio_dir);
    check_value("reset irq", 0, o_irq);
  endtask

  task automatic test_host_timing();
    host_resp_t  resp;
    int          edges;
    int          pulses;
    send_request(1'b0, slot_addr(`SOC_SLOT_PNP, 12'h000), 32'h0);
    check_value("timing busy in transfer", 1, o_busy);
    wait_response(resp, edges);
    check_value("timing latency", 3, edges);
    check_value("timing mapped err", 0, resp.err);
    check_value("timing mapped rdata", `SOC_HW_ID, resp.rdata);
    // Second strobe sampled while the response pulse keeps the bridge busy
    check_value("timing busy in pulse", 1, o_busy);
    i_req       = 1'b1;
    i_host.we   = 1'b0;
    i_host.addr = slot_addr(`SOC_SLOT_PNP, 12'h004);
    next_cycle();
    i_req = 1'b0;
    check_value("timing pulse width", 0, o_resp_valid);
    check_value("timing busy after pulse", 0, o_busy);
    pulses = 0;
    repeat (10)
    begin
      if (o_resp_valid)
        pulses++;
      next_cycle();
    end
    check_value("timing ignored strobe pulses", 0, pulses);
    // Outside the window and then an empty slot inside it
    host_read(32'h2000_0040, resp);
    check_value("unmapped window err", 1, resp.err);
    check_value("unmapped window rdata", 0, resp.rdata);
    host_read(slot_addr(4'd3, 12'h000), resp);
    check_value("unmapped slot err", 1, resp.err);
    check_value("unmapped slot rdata", 0, resp.rdata);
  endtask

  task automatic test_gpio();
    logic [31:0] dir;
    logic [31:0] out;
    logic [31:0] pins;
    for (int n = 0; n < 4; n++)
    begin
      dir = $random(seed) & GPIO_MASK;
      out = $random(seed) & GPIO_MASK;
      host_write(slot_addr(`SOC_SLOT_GPIO, 12'h000), dir);
      host_write(slot_addr(`SOC_SLOT_GPIO, 12'h004), out);
      read_expect("gpio dir readback", slot_addr(`SOC_SLOT_GPIO, 12'h000), dir);
      read_expect("gpio out readback", slot_addr(`SOC_SLOT_GPIO, 12'h004), out);
      check_value("gpio pins", out & dir, o_gpio);
      check_value("gpio dir pins", dir, o_gpio_dir);
    end
    // Interrupts still masked so edges here set nothing
    pins   = $random(seed) & GPIO_MASK;
    i_gpio = pins[GW-1:0];
    repeat (4) next_cycle();
    read_expect("gpio input", slot_addr(`SOC_SLOT_GPIO, 12'h008), pins);
    i_gpio = '0;
    repeat (4) next_cycle();
  endtask

  task automatic test_pnp();
    logic [11:0] row;
    read_expect("pnp hw id", slot_addr(`SOC_SLOT_PNP, 12'h000), `SOC_HW_ID);
    read_expect("pnp slot count", slot_addr(`SOC_SLOT_PNP, 12'h004), `SOC_SLOT_TOTAL);
    for (int s = 0; s < `SOC_SLOT_TOTAL; s++)
    begin
      row = (s + 1) << 4;
      read_expect($sformatf("pnp slot %0d start", s), slot_addr(`SOC_SLOT_PNP, row),
                  slot_addr(s, 12'h000));
      read_expect($sformatf("pnp slot %0d end", s), slot_addr(`SOC_SLOT_PNP, row + 12'h4),
                  slot_addr(s, 12'hfff));
      read_expect($sformatf("pnp slot %0d id", s), slot_addr(`SOC_SLOT_PNP, row + 12'h8),
                  {`SOC_VENDOR_ID, slot_device(s)});
    end
  endtask

  task automatic test_irq_gpio();
    int          k;
    int          m;
    logic [31:0] bit_k;
    k     = $unsigned($random(seed)) % GW;
    // Any other pin
    m     = (k + 1 + $unsigned($random(seed)) % (GW - 1)) % GW;
    bit_k = 32'd1 << k;
    host_write(slot_addr(`SOC_SLOT_GPIO, 12'h00c), bit_k);
    host_write(slot_addr(`SOC_SLOT_IRQ, 12'h004), bit_k);
    i_gpio[k] = 1'b1;
    repeat (6) next_cycle();
    read_expect("gpio pending", slot_addr(`SOC_SLOT_GPIO, 12'h010), bit_k);
    read_expect("irq pending", slot_addr(`SOC_SLOT_IRQ, 12'h000), bit_k);
    check_value("irq line gpio", 1, o_irq);
    read_expect("irq claim gpio", slot_addr(`SOC_SLOT_IRQ, 12'h008), k + 1);
    // GPIO first since the controller relatches a source still high
    host_write(slot_addr(`SOC_SLOT_GPIO, 12'h010), bit_k);
    host_write(slot_addr(`SOC_SLOT_IRQ, 12'h000), bit_k);
    check_value("irq line cleared", 0, o_irq);
    read_expect("irq pending cleared", slot_addr(`SOC_SLOT_IRQ, 12'h000), 0);
    read_expect("irq claim idle", slot_addr(`SOC_SLOT_IRQ, 12'h008), 0);
    i_gpio = '0;
    repeat (4) next_cycle();
    // Edge on a masked pin
    i_gpio[m] = 1'b1;
    repeat (6) next_cycle();
    read_expect("gpio masked pending", slot_addr(`SOC_SLOT_GPIO, 12'h010), 0);
    read_expect("irq masked pending", slot_addr(`SOC_SLOT_IRQ, 12'h000), 0);
    check_value("irq line masked", 0, o_irq);
    i_gpio = '0;
    repeat (4) next_cycle();
  endtask

  task automatic test_irq_ext();
    int          j;
    logic [31:0] rnd;
    logic [EW-1:0] lines;
    j = $unsigned($random(seed)) % EW;
    host_write(slot_addr(`SOC_SLOT_IRQ, 12'h004), 32'd1 << (GW + j));
    i_ext_irq[j] = 1'b1;
    repeat (3) next_cycle();
    check_value("irq line ext", 1, o_irq);
    read_expect("irq claim ext", slot_addr(`SOC_SLOT_IRQ, 12'h008), GW + 1 + j);
    // Every external line enabled with line j still pending
    host_write(slot_addr(`SOC_SLOT_IRQ, 12'h004), ((32'd1 << EW) - 1) << GW);
    rnd       = $random(seed);
    lines     = rnd[EW-1:0];
    i_ext_irq = lines;
    repeat (3) next_cycle();
    lines = lines | (EW'(1) << j);
    read_expect("irq pending ext", slot_addr(`SOC_SLOT_IRQ, 12'h000), 32'(lines) << GW);
    read_expect("irq claim lowest ext", slot_addr(`SOC_SLOT_IRQ, 12'h008),
                GW + 1 + lowest_set(lines));
    i_ext_irq = '0;
    next_cycle();
    host_write(slot_addr(`SOC_SLOT_IRQ, 12'h000), 32'hffff);
    check_value("irq line ext cleared", 0, o_irq);
  endtask

  //////////////////////////////
  // Sequence

  initial
  begin
    i_rst_n   = 1'b0;
    i_req     = 1'b0;
    i_host    = '0;
    i_gpio    = '0;
    i_ext_irq = '0;
    repeat (5) @(posedge i_sys_clk);
    #1;
    i_rst_n = 1'b1;
    test_reset();
    test_host_timing();
    test_gpio();
    test_pnp();
    test_irq_gpio();
    test_irq_ext();
    $display("Test passed");
    $finish;
  end

endmodule

/* soc_periph.f */
+incdir+.
soc_pkg.sv
apb_bridge.sv
apb_gpio.sv
apb_irqctrl.sv
apb_pnp.sv
soc_periph.sv
tb_soc_periph.sv

/* Bender.yml */
package:
  name: soc_periph

export_include_dirs:
  - .

sources:
  # Package first, then the peripherals, then the top level
  - files:
      - soc_pkg.sv
      - apb_bridge.sv
      - apb_gpio.sv
      - apb_irqctrl.sv
      - apb_pnp.sv
      - soc_periph.sv

  # Directed testbench
  - target: test
    files:
      - tb_soc_periph.sv
